// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Mdir obj_dir
TOP       = prim_unit_tb
FILELIST  = compile.f

SRCS = $(filter-out +%,$(shell cat $(FILELIST))) tb/prim_model.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: common/cmd_pkg.sv
package cmd_pkg;

  // Host opcodes, one command per strobe
  typedef enum logic [3:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_and   = 4'd2,
    op_or    = 4'd3,
    op_xor   = 4'd4,
    op_not   = 4'd5,
    op_lsh   = 4'd6,
    op_rsh   = 4'd7,
    op_lt    = 4'd8,
    op_gt    = 4'd9,
    op_eq    = 4'd10,
    op_neq   = 4'd11,
    op_le    = 4'd12,
    op_ge    = 4'd13,
    op_mul   = 4'd14,
    op_mulfx = 4'd15
  } op_e;

  // Host tag, returned untouched with the result
  typedef logic [3:0] tag_t;

  // Command header that travels beside the two operands
  typedef struct packed {
    op_e  op;
    tag_t tag;
  } cmd_hdr_t;

  // Result header, zero is set when the result data is all zeros
  typedef struct packed {
    tag_t tag;
    logic zero;
  } res_hdr_t;

endpackage

// File: common/exec_pkg.sv
package exec_pkg;

  // Which execution block handles a command
  typedef enum logic {
    unit_alu = 1'b0,
    unit_mul = 1'b1
  } unit_e;

  // ALU functions, one for each non-multiply opcode
  typedef enum logic [3:0] {
    fn_add = 4'd0,
    fn_sub = 4'd1,
    fn_and = 4'd2,
    fn_or  = 4'd3,
    fn_xor = 4'd4,
    fn_not = 4'd5,
    fn_lsh = 4'd6,
    fn_rsh = 4'd7,
    fn_lt  = 4'd8,
    fn_gt  = 4'd9,
    fn_eq  = 4'd10,
    fn_neq = 4'd11,
    fn_le  = 4'd12,
    fn_ge  = 4'd13
  } alu_fn_e;

  // Decoded control word carried down the pipeline
  typedef struct packed {
    unit_e         unit;
    alu_fn_e       alu_fn;
    logic          mul_fx;
    cmd_pkg::tag_t tag;
  } ctrl_t;

endpackage

// File: compile.f
+incdir+tb
common/cmd_pkg.sv
common/exec_pkg.sv
logic/op_decode.sv
execute/alu_ops.sv
execute/fx_mult_pipe.sv
execute/execute_unit.sv
logic/result_stage.sv
logic/prim_unit_top.sv
tb/prim_unit_tb.sv

// File: execute/alu_ops.sv
`timescale 1ns/1ps

module alu_ops #(
  parameter int WIDTH = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  exec_pkg::alu_fn_e alu_fn,
  input  logic [WIDTH-1:0]  a,
  input  logic [WIDTH-1:0]  b,
  output logic              out_valid,
  output logic [WIDTH-1:0]  result
);
  import exec_pkg::*;

  localparam logic [WIDTH-2:0] CMP_PAD = '0;

  logic [WIDTH-1:0] alu_comb;
  logic [WIDTH-1:0] result_q1;
  logic             valid_q1;

  // Combinational primitives, compares land in bit 0
  always_comb begin
    case (alu_fn)
      fn_add:  alu_comb = a + b;
      fn_sub:  alu_comb = a - b;
      fn_and:  alu_comb = a & b;
      fn_or:   alu_comb = a | b;
      fn_xor:  alu_comb = a ^ b;
      fn_not:  alu_comb = ~a;
      // Full-width shift amount, so b >= WIDTH clears the result
      fn_lsh:  alu_comb = a << b;
      fn_rsh:  alu_comb = a >> b;
      fn_lt:   alu_comb = {CMP_PAD, a < b};
      fn_gt:   alu_comb = {CMP_PAD, a > b};
      fn_eq:   alu_comb = {CMP_PAD, a == b};
      fn_neq:  alu_comb = {CMP_PAD, a != b};
      fn_le:   alu_comb = {CMP_PAD, a <= b};
      fn_ge:   alu_comb = {CMP_PAD, a >= b};
      default: alu_comb = '0;
    endcase
  end

  // Two register stages to line up with the multiplier
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q1  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_q1  <= in_valid;
      out_valid <= valid_q1;
    end
  end

  always_ff @(posedge clk) begin
    result_q1 <= alu_comb;
    result    <= result_q1;
  end

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

module execute_unit #(
  parameter int WIDTH     = 16,
  parameter int INT_WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             dec_valid,
  input  exec_pkg::ctrl_t  dec_ctrl,
  input  logic [WIDTH-1:0] dec_a,
  input  logic [WIDTH-1:0] dec_b,
  output logic             exe_valid,
  output exec_pkg::ctrl_t  exe_ctrl,
  output logic [WIDTH-1:0] exe_alu,
  output logic [WIDTH-1:0] exe_mul
);
  import exec_pkg::*;

  logic  alu_start;
  logic  mul_start;
  logic  alu_done;
  logic  mul_done;
  ctrl_t ctrl_q1;

  // Only the selected unit sees the strobe
  assign alu_start = dec_valid && (dec_ctrl.unit == unit_alu);
  assign mul_start = dec_valid && (dec_ctrl.unit == unit_mul);

  alu_ops #(
    .WIDTH(WIDTH)
  ) u_alu_ops (
    .clk      (clk),
    .reset    (reset),
    .in_valid (alu_start),
    .alu_fn   (dec_ctrl.alu_fn),
    .a        (dec_a),
    .b        (dec_b),
    .out_valid(alu_done),
    .result   (exe_alu)
  );

  fx_mult_pipe #(
    .WIDTH    (WIDTH),
    .INT_WIDTH(INT_WIDTH)
  ) u_fx_mult_pipe (
    .clk      (clk),
    .reset    (reset),
    .in_valid (mul_start),
    .fx       (dec_ctrl.mul_fx),
    .a        (dec_a),
    .b        (dec_b),
    .out_valid(mul_done),
    .product  (exe_mul)
  );

  // Control word rides two stages beside the units
  always_ff @(posedge clk) begin
    ctrl_q1  <= dec_ctrl;
    exe_ctrl <= ctrl_q1;
  end

  // At most one unit finishes in any cycle
  assign exe_valid = alu_done | mul_done;

endmodule

// File: execute/fx_mult_pipe.sv
`timescale 1ns/1ps

module fx_mult_pipe #(
  parameter int WIDTH     = 16,
  parameter int INT_WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  logic             fx,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic             out_valid,
  output logic [WIDTH-1:0] product
);
  logic [WIDTH-1:0]   a_q;
  logic [WIDTH-1:0]   b_q;
  logic               fx_q1;
  logic               valid_q1;
  logic [2*WIDTH-1:0] a_ext;
  logic [2*WIDTH-1:0] b_ext;
  logic [2*WIDTH-1:0] prod_q;
  logic               fx_q2;

  // Valid walks the two stages, a new multiply may enter every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q1  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_q1  <= in_valid;
      out_valid <= valid_q1;
    end
  end

  // Stage one holds the operands and the mode
  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_q   <= a;
      b_q   <= b;
      fx_q1 <= fx;
    end
  end

  // Sign extend in fixed-point mode, the low 2*WIDTH bits then give the
  // signed product, while zero extension gives the unsigned one
  always_comb begin
    if (fx_q1) begin
      a_ext = {{WIDTH{a_q[WIDTH-1]}}, a_q};
      b_ext = {{WIDTH{b_q[WIDTH-1]}}, b_q};
    end else begin
      a_ext = {{WIDTH{1'b0}}, a_q};
      b_ext = {{WIDTH{1'b0}}, b_q};
    end
  end

  // Stage two holds the full double-width product
  always_ff @(posedge clk) begin
    prod_q <= a_ext * b_ext;
    fx_q2  <= fx_q1;
  end

  // Fixed-point slice keeps INT_WIDTH integer bits
  assign product = fx_q2 ? prod_q[2*WIDTH-INT_WIDTH-1:WIDTH-INT_WIDTH]
                         : prod_q[WIDTH-1:0];

endmodule

// File: logic/op_decode.sv
`timescale 1ns/1ps

module op_decode #(
  parameter int WIDTH = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_valid,
  input  cmd_pkg::cmd_hdr_t cmd_hdr,
  input  logic [WIDTH-1:0]  cmd_a,
  input  logic [WIDTH-1:0]  cmd_b,
  output logic              dec_valid,
  output exec_pkg::ctrl_t   dec_ctrl,
  output logic [WIDTH-1:0]  dec_a,
  output logic [WIDTH-1:0]  dec_b
);
  import cmd_pkg::*;
  import exec_pkg::*;

  ctrl_t ctrl_next;

  // Opcode to unit, function and fixed-point mode
  always_comb begin
    ctrl_next.unit   = unit_alu;
    ctrl_next.alu_fn = fn_add;
    ctrl_next.mul_fx = 1'b0;
    ctrl_next.tag    = cmd_hdr.tag;
    case (cmd_hdr.op)
      op_add:   ctrl_next.alu_fn = fn_add;
      op_sub:   ctrl_next.alu_fn = fn_sub;
      op_and:   ctrl_next.alu_fn = fn_and;
      op_or:    ctrl_next.alu_fn = fn_or;
      op_xor:   ctrl_next.alu_fn = fn_xor;
      op_not:   ctrl_next.alu_fn = fn_not;
      op_lsh:   ctrl_next.alu_fn = fn_lsh;
      op_rsh:   ctrl_next.alu_fn = fn_rsh;
      op_lt:    ctrl_next.alu_fn = fn_lt;
      op_gt:    ctrl_next.alu_fn = fn_gt;
      op_eq:    ctrl_next.alu_fn = fn_eq;
      op_neq:   ctrl_next.alu_fn = fn_neq;
      op_le:    ctrl_next.alu_fn = fn_le;
      op_ge:    ctrl_next.alu_fn = fn_ge;
      op_mul:   ctrl_next.unit   = unit_mul;
      op_mulfx: begin
        ctrl_next.unit   = unit_mul;
        ctrl_next.mul_fx = 1'b1;
      end
      default:  ctrl_next.alu_fn = fn_add;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= cmd_valid;
    end
  end

  // Payload is only captured on a strobe
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      dec_ctrl <= ctrl_next;
      dec_a    <= cmd_a;
      dec_b    <= cmd_b;
    end
  end

endmodule

// File: logic/prim_unit_top.sv
`timescale 1ns/1ps

module prim_unit_top #(
  parameter int WIDTH     = 16,
  parameter int INT_WIDTH = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_valid,
  input  cmd_pkg::cmd_hdr_t cmd_hdr,
  input  logic [WIDTH-1:0]  cmd_a,
  input  logic [WIDTH-1:0]  cmd_b,
  output logic              res_valid,
  output cmd_pkg::res_hdr_t res_hdr,
  output logic [WIDTH-1:0]  res_data
);
  import exec_pkg::*;

  logic             dec_valid;
  ctrl_t            dec_ctrl;
  logic [WIDTH-1:0] dec_a;
  logic [WIDTH-1:0] dec_b;
  logic             exe_valid;
  ctrl_t            exe_ctrl;
  logic [WIDTH-1:0] exe_alu;
  logic [WIDTH-1:0] exe_mul;

  // Decode, one cycle
  op_decode #(
    .WIDTH(WIDTH)
  ) u_op_decode (
    .clk      (clk),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_hdr  (cmd_hdr),
    .cmd_a    (cmd_a),
    .cmd_b    (cmd_b),
    .dec_valid(dec_valid),
    .dec_ctrl (dec_ctrl),
    .dec_a    (dec_a),
    .dec_b    (dec_b)
  );

  // Execute, two cycles
  execute_unit #(
    .WIDTH    (WIDTH),
    .INT_WIDTH(INT_WIDTH)
  ) u_execute_unit (
    .clk      (clk),
    .reset    (reset),
    .dec_valid(dec_valid),
    .dec_ctrl (dec_ctrl),
    .dec_a    (dec_a),
    .dec_b    (dec_b),
    .exe_valid(exe_valid),
    .exe_ctrl (exe_ctrl),
    .exe_alu  (exe_alu),
    .exe_mul  (exe_mul)
  );

  // Result select and zero flag, one cycle
  result_stage #(
    .WIDTH(WIDTH)
  ) u_result_stage (
    .clk      (clk),
    .reset    (reset),
    .exe_valid(exe_valid),
    .exe_ctrl (exe_ctrl),
    .exe_alu  (exe_alu),
    .exe_mul  (exe_mul),
    .res_valid(res_valid),
    .res_hdr  (res_hdr),
    .res_data (res_data)
  );

endmodule

// File: logic/result_stage.sv
`timescale 1ns/1ps

module result_stage #(
  parameter int WIDTH = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              exe_valid,
  input  exec_pkg::ctrl_t   exe_ctrl,
  input  logic [WIDTH-1:0]  exe_alu,
  input  logic [WIDTH-1:0]  exe_mul,
  output logic              res_valid,
  output cmd_pkg::res_hdr_t res_hdr,
  output logic [WIDTH-1:0]  res_data
);
  import exec_pkg::*;

  logic [WIDTH-1:0] data_sel;
  logic             data_zero;

  assign data_sel  = (exe_ctrl.unit == unit_mul) ? exe_mul : exe_alu;
  assign data_zero = (data_sel == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    res_data     <= data_sel;
    res_hdr.tag  <= exe_ctrl.tag;
    res_hdr.zero <= data_zero;
  end

endmodule

// File: tb/prim_model.svh
`ifndef PRIM_MODEL_SVH
`define PRIM_MODEL_SVH

// Expected result of one command, with the cycle it was issued in
typedef struct packed {
  tag_t             tag;
  logic [WIDTH-1:0] data;
  logic             zero;
  logic [31:0]      cyc;
} exp_t;

exp_t exp_q[$];

// Result data from the opcode rules
function automatic logic [WIDTH-1:0] model_data(op_e op, logic [WIDTH-1:0] a,
                                                logic [WIDTH-1:0] b);
  longint           wide;
  logic [WIDTH-1:0] r;
  r = '0;
  case (op)
    op_add:   r = a + b;
    op_sub:   r = a - b;
    op_and:   r = a & b;
    op_or:    r = a | b;
    op_xor:   r = a ^ b;
    op_not:   r = ~a;
    // Any shift of WIDTH or more empties the word
    op_lsh:   r = (b >= WIDTH) ? '0 : (a << b);
    op_rsh:   r = (b >= WIDTH) ? '0 : (a >> b);
    op_lt:    r = (a < b) ? 1 : 0;
    op_gt:    r = (a > b) ? 1 : 0;
    op_eq:    r = (a == b) ? 1 : 0;
    op_neq:   r = (a != b) ? 1 : 0;
    op_le:    r = (a <= b) ? 1 : 0;
    op_ge:    r = (a >= b) ? 1 : 0;
    op_mul: begin
      wide = longint'(a) * longint'(b);
      r    = wide[WIDTH-1:0];
    end
    op_mulfx: begin
      // Signed product, keep INT_WIDTH integer bits and the fraction below
      wide = longint'($signed(a)) * longint'($signed(b));
      r    = wide[2*WIDTH-INT_WIDTH-1:WIDTH-INT_WIDTH];
    end
    default:  r = '0;
  endcase
  return r;
endfunction

`endif

// File: tb/prim_unit_tb.sv
`timescale 1ns/1ps

module prim_unit_tb;
  import cmd_pkg::*;

  localparam int WIDTH     = 16;
  localparam int INT_WIDTH = 8;
  localparam int DRAIN_MAX = 20;

  `include "prim_model.svh"

  logic             clk = 1'b0;
  logic             reset;
  logic             cmd_valid;
  cmd_hdr_t         cmd_hdr;
  logic [WIDTH-1:0] cmd_a;
  logic [WIDTH-1:0] cmd_b;
  logic             res_valid;
  res_hdr_t         res_hdr;
  logic [WIDTH-1:0] res_data;

  logic [31:0] cyc = '0;
  tag_t        next_tag = '0;
  int          errors = 0;
  int          checks = 0;
  int          err_base;
  int          chk_base;
  string       cur_test = "none";
  exp_t        got;

  prim_unit_top #(
    .WIDTH    (WIDTH),
    .INT_WIDTH(INT_WIDTH)
  ) u_dut (
    .clk      (clk),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_hdr  (cmd_hdr),
    .cmd_a    (cmd_a),
    .cmd_b    (cmd_b),
    .res_valid(res_valid),
    .res_hdr  (res_hdr),
    .res_data (res_data)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  // Results sampled on the falling edge where they are stable
  always @(negedge clk) begin
    if (reset === 1'b1) begin
      if (res_valid !== 1'b0) begin
        $display("Error in %s: res_valid was not low during reset", cur_test);
        errors++;
      end
    end else if (res_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Error in %s: result tag %0h arrived with no command outstanding",
                 cur_test, res_hdr.tag);
        errors++;
      end else begin
        got = exp_q.pop_front();
        check_value("tag", 32'(got.tag), 32'(res_hdr.tag));
        check_value("data", 32'(got.data), 32'(res_data));
        check_value("zero", 32'(got.zero), 32'(res_hdr.zero));
        check_value("latency", 32'd4, cyc - got.cyc);
      end
    end else if (res_valid !== 1'b0) begin
      $display("Error in %s: res_valid is unknown after reset", cur_test);
      errors++;
    end
  end

  function automatic logic [WIDTH-1:0] rand_word();
    logic [31:0] r;
    r = $urandom();
    return r[WIDTH-1:0];
  endfunction

  function automatic logic [WIDTH-1:0] rand_upto(int unsigned max);
    logic [31:0] r;
    r = $urandom_range(max);
    return r[WIDTH-1:0];
  endfunction

  task automatic issue_cmd(op_e op, logic [WIDTH-1:0] a, logic [WIDTH-1:0] b);
    exp_t e;
    @(posedge clk);
    #1;
    cmd_valid   = 1'b1;
    cmd_hdr.op  = op;
    cmd_hdr.tag = next_tag;
    cmd_a       = a;
    cmd_b       = b;
    e.tag  = next_tag;
    e.data = model_data(op, a, b);
    e.zero = (e.data == '0);
    e.cyc  = cyc;
    exp_q.push_back(e);
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  // Wait until every issued command has come back
  task automatic wait_drain();
    int n;
    n = 0;
    idle_cycle();
    while (exp_q.size() != 0 && n < DRAIN_MAX) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Error in %s: timed out with %0d results never returned",
               cur_test, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic start_test(string name);
    cur_test = name;
    err_base = errors;
    chk_base = checks;
  endtask

  task automatic end_test();
    $display("Test %s finished: %0d checks, %0d errors", cur_test,
             checks - chk_base, errors - err_base);
  endtask

  initial begin
    op_e              op;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    void'($urandom(32'h332d_80db));
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_hdr   = '0;
    cmd_a     = '0;
    cmd_b     = '0;

    start_test("reset_idle");
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    repeat (10) @(posedge clk);
    end_test();

    start_test("latency");
    for (int i = 0; i < 16; i++) begin
      issue_cmd(op_e'(i[3:0]), rand_word(), rand_word());
      wait_drain();
    end
    end_test();

    start_test("logic_arith");
    for (int i = 0; i < 300; i++) begin
      op = op_e'(rand_upto(7));
      a  = rand_word();
      // Mostly small shift amounts and some past the word width
      if ((op == op_lsh || op == op_rsh) && $urandom_range(3) != 0) begin
        b = rand_upto(20);
      end else begin
        b = rand_word();
      end
      issue_cmd(op, a, b);
    end
    wait_drain();
    end_test();

    start_test("compare");
    for (int i = 0; i < 200; i++) begin
      op = op_e'(4'd8 + rand_upto(5));
      a  = rand_word();
      b  = ($urandom_range(3) == 0) ? a : rand_word();
      issue_cmd(op, a, b);
    end
    wait_drain();
    end_test();

    start_test("multiply");
    for (int i = 0; i < 200; i++) begin
      op = ($urandom_range(1) == 0) ? op_mul : op_mulfx;
      issue_cmd(op, rand_word(), rand_word());
    end
    wait_drain();
    end_test();

    start_test("mixed_stream");
    for (int i = 0; i < 400; i++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
      issue_cmd(op_e'(rand_upto(15)), rand_word(), rand_word());
    end
    wait_drain();
    end_test();

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
